/* src/lsu_pkg.sv */
/*
 * Load/store unit shared definitions
 * Widths, plain vector types, access size and control state enums
 */
package lsu_pkg;

    // Instruction ids, one queue entry per id
    localparam int ID_W         = 3;
    localparam int MAX_INFLIGHT = 1 << ID_W;

    // Arrival-order FIFO pointer and occupancy widths
    localparam int FIFO_PTR_W = $clog2(MAX_INFLIGHT);
    localparam int FIFO_CNT_W = $clog2(MAX_INFLIGHT + 1);

    // Low address bits compared by the conflict check
    localparam int TAG_W = 3;

    // Data RAM geometry
    // word address comes from byte address bits 7:2
    localparam int RAM_WORDS = 64;
    localparam int RAM_AW    = 6;

    typedef logic [ID_W-1:0] id_t;
    typedef logic [31:0]     addr_t;
    typedef logic [31:0]     word_t;
    typedef logic [3:0]      byte_en_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_t;

    // Control FSM
    typedef enum logic {
        ST_IDLE      = 1'b0,
        ST_LOAD_HOLD = 1'b1
    } lsu_state_t;

endpackage

/* src/id_fifo.sv */
/*
 * Instruction id FIFO
 * Records the arrival order of queue entries so per-id storage leaves in order
 */
module id_fifo (
    input  logic         clk,
    input  logic         rst,
    input  logic         push,
    input  logic         pop,
    input  lsu_pkg::id_t push_id,
    output lsu_pkg::id_t oldest_id,
    output logic         empty
);

    lsu_pkg::id_t                   ids [lsu_pkg::MAX_INFLIGHT];
    logic [lsu_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [lsu_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [lsu_pkg::FIFO_CNT_W-1:0] count;

    // Id storage
    always_ff @(posedge clk) begin
        if (push) begin
            ids[wr_ptr] <= push_id;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Oldest id is a plain level, read straight from storage
    assign oldest_id = ids[rd_ptr];
    assign empty     = (count == '0);

endmodule

/* src/load_store_queue.sv */
/*
 * Load/store queue
 * Per-id request storage with in-order issue through an id FIFO,
 * writeback capture for stores waiting on data, store address conflict
 * check and lane replication of the head store data
 */
module load_store_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  lsu_pkg::id_t          req_id,
    input  logic                  req_load,
    input  logic                  req_store,
    input  lsu_pkg::addr_t        req_addr,
    input  lsu_pkg::access_size_t req_size,
    input  logic                  req_unsigned,
    input  lsu_pkg::word_t        req_data,
    input  logic                  req_data_valid,
    input  lsu_pkg::id_t          req_data_id,
    output logic                  req_ready,
    input  logic                  wb_valid,
    input  lsu_pkg::id_t          wb_id,
    input  lsu_pkg::word_t        wb_data,
    input  lsu_pkg::addr_t        cmp_addr,
    output logic                  addr_conflict,
    input  logic                  issue,
    output logic                  head_ready,
    output logic                  head_load,
    output lsu_pkg::addr_t        head_addr,
    output lsu_pkg::access_size_t head_size,
    output logic                  head_unsigned,
    output lsu_pkg::word_t        head_data,
    output lsu_pkg::id_t          oldest_id
);

    // Entry state bits, one per id
    logic [lsu_pkg::MAX_INFLIGHT-1:0] valid;
    logic [lsu_pkg::MAX_INFLIGHT-1:0] is_store;
    // Indexed by the producing id, not the store's own id
    logic [lsu_pkg::MAX_INFLIGHT-1:0] waiting_for_data;

    // Set and clear masks
    logic [lsu_pkg::MAX_INFLIGHT-1:0] new_id_one_hot;
    logic [lsu_pkg::MAX_INFLIGHT-1:0] need_data_one_hot;
    logic [lsu_pkg::MAX_INFLIGHT-1:0] issue_one_hot;
    logic [lsu_pkg::MAX_INFLIGHT-1:0] wb_one_hot;

    // Per-id attributes
    logic                      attr_load     [lsu_pkg::MAX_INFLIGHT];
    lsu_pkg::addr_t            attr_addr     [lsu_pkg::MAX_INFLIGHT];
    lsu_pkg::access_size_t     attr_size     [lsu_pkg::MAX_INFLIGHT];
    logic                      attr_unsigned [lsu_pkg::MAX_INFLIGHT];
    lsu_pkg::id_t              data_ids      [lsu_pkg::MAX_INFLIGHT];
    lsu_pkg::word_t            store_data    [lsu_pkg::MAX_INFLIGHT];
    logic [lsu_pkg::TAG_W-1:0] tag_addr      [lsu_pkg::MAX_INFLIGHT];

    logic           accept;
    logic           wb_capture;
    logic           store_data_we;
    logic           fifo_empty;
    lsu_pkg::id_t   head_data_id;
    lsu_pkg::word_t head_raw;

    id_fifo id_fifo_inst (
        .clk       (clk),
        .rst       (rst),
        .push      (accept),
        .pop       (issue),
        .push_id   (req_id),
        .oldest_id (oldest_id),
        .empty     (fifo_empty)
    );

    //////////////////////////////////////////////////
    // Request acceptance

    // Writeback owns the single store-data write port
    assign wb_capture = wb_valid & waiting_for_data[wb_id];
    assign req_ready  = ~(req_store & wb_capture);
    assign accept     = req_valid & req_ready;

    always_comb begin
        new_id_one_hot                 = '0;
        new_id_one_hot[req_id]         = accept;
        need_data_one_hot              = '0;
        need_data_one_hot[req_data_id] = accept & req_store & ~req_data_valid;
        issue_one_hot                  = '0;
        issue_one_hot[oldest_id]       = issue;
        wb_one_hot                     = '0;
        wb_one_hot[wb_id]              = wb_valid;
    end

    // Attributes, single write port on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            attr_load[req_id]     <= req_load;
            attr_addr[req_id]     <= req_addr;
            attr_size[req_id]     <= req_size;
            attr_unsigned[req_id] <= req_unsigned;
            tag_addr[req_id]      <= req_addr[lsu_pkg::TAG_W-1:0];
            // Data present now lives under the store's own id
            data_ids[req_id]      <= req_data_valid ? req_id : req_data_id;
        end
    end

    // Store data, writeback first
    assign store_data_we = wb_capture | (accept & req_store & req_data_valid);

    always_ff @(posedge clk) begin
        if (store_data_we) begin
            store_data[wb_capture ? wb_id : req_id] <= wb_capture ? wb_data : req_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid            <= '0;
            is_store         <= '0;
            waiting_for_data <= '0;
        end else begin
            valid            <= (valid | new_id_one_hot) & ~issue_one_hot;
            is_store         <= (is_store | (new_id_one_hot & {lsu_pkg::MAX_INFLIGHT{req_store}}))
                                & ~issue_one_hot;
            waiting_for_data <= (waiting_for_data | need_data_one_hot) & ~wb_one_hot;
        end
    end

    //////////////////////////////////////////////////
    // Conflict check

    // Only queued stores count, issued entries are already cleared
    always_comb begin
        addr_conflict = 1'b0;
        for (int i = 0; i < lsu_pkg::MAX_INFLIGHT; i++) begin
            addr_conflict |= valid[i] & is_store[i]
                             & (tag_addr[i] == cmp_addr[lsu_pkg::TAG_W-1:0]);
        end
    end

    //////////////////////////////////////////////////
    // Head of queue

    assign head_data_id  = data_ids[oldest_id];
    assign head_load     = attr_load[oldest_id];
    assign head_addr     = attr_addr[oldest_id];
    assign head_size     = attr_size[oldest_id];
    assign head_unsigned = attr_unsigned[oldest_id];
    assign head_raw      = store_data[head_data_id];

    // A waiting store holds the head, so later requests wait behind it
    assign head_ready = ~fifo_empty & valid[oldest_id]
                        & (head_load | ~waiting_for_data[head_data_id]);

    // Replicate sub-word data into every lane the byte enables can pick
    always_comb begin
        case (head_size)
            lsu_pkg::SIZE_BYTE: head_data = {4{head_raw[7:0]}};
            lsu_pkg::SIZE_HALF: head_data = {2{head_raw[15:0]}};
            default:            head_data = head_raw;
        endcase
    end

endmodule

/* src/data_ram.sv */
/*
 * Data RAM
 * 64 words with per-byte write enables and a registered read port
 */
module data_ram (
    input  logic                        clk,
    input  logic                        we,
    input  logic                        re,
    input  logic [lsu_pkg::RAM_AW-1:0]  addr,
    input  lsu_pkg::byte_en_t           be,
    input  lsu_pkg::word_t              wdata,
    output lsu_pkg::word_t              rdata
);

    logic [3:0][7:0] mem [lsu_pkg::RAM_WORDS];

    // Byte-lane writes
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[addr][b] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Read data holds between reads
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

/* src/load_align.sv */
/*
 * Load aligner
 * Moves the addressed byte or halfword to bit 0 and extends it
 */
module load_align (
    input  lsu_pkg::word_t        word,
    input  logic [1:0]            byte_off,
    input  lsu_pkg::access_size_t size,
    input  logic                  is_unsigned,
    output lsu_pkg::word_t        data
);

    lsu_pkg::word_t shifted;
    logic           byte_sign;
    logic           half_sign;

    // Addressed lane down to bit 0
    assign shifted = word >> {byte_off, 3'b000};

    // Sign bit only when a signed load
    assign byte_sign = ~is_unsigned & shifted[7];
    assign half_sign = ~is_unsigned & shifted[15];

    always_comb begin
        case (size)
            lsu_pkg::SIZE_BYTE: data = {{24{byte_sign}}, shifted[7:0]};
            lsu_pkg::SIZE_HALF: data = {{16{half_sign}}, shifted[15:0]};
            // Full words are never shifted
            default:            data = word;
        endcase
    end

endmodule

/* src/lsu_control.sv */
/*
 * Load/store control
 * Issues the oldest ready queue entry to the RAM, forms byte enables
 * and holds each load result until it is acknowledged
 */
module lsu_control (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       head_ready,
    input  logic                       head_load,
    input  lsu_pkg::addr_t             head_addr,
    input  lsu_pkg::access_size_t      head_size,
    input  logic                       head_unsigned,
    input  lsu_pkg::word_t             head_data,
    input  logic                       load_ack,
    input  lsu_pkg::id_t               oldest_id,
    output logic                       issue,
    output logic                       ram_we,
    output logic                       ram_re,
    output logic [lsu_pkg::RAM_AW-1:0] ram_addr,
    output lsu_pkg::byte_en_t          ram_be,
    output lsu_pkg::word_t             ram_wdata,
    output logic                       load_valid,
    output lsu_pkg::id_t               load_id,
    output logic [1:0]                 load_byte_off,
    output lsu_pkg::access_size_t      load_size,
    output logic                       load_unsigned
);

    lsu_pkg::lsu_state_t state;
    lsu_pkg::lsu_state_t state_next;

    //////////////////////////////////////////////////
    // Issue

    // No issue while a load result is outstanding
    assign issue = (state == lsu_pkg::ST_IDLE) & head_ready;

    // Stores write at the issue edge, loads read at it
    assign ram_we    = issue & ~head_load;
    assign ram_re    = issue & head_load;
    assign ram_addr  = head_addr[lsu_pkg::RAM_AW+1:2];
    assign ram_wdata = head_data;

    always_comb begin
        case (head_size)
            lsu_pkg::SIZE_BYTE: ram_be = 4'b0001 << head_addr[1:0];
            lsu_pkg::SIZE_HALF: ram_be = head_addr[1] ? 4'b1100 : 4'b0011;
            default:            ram_be = 4'b1111;
        endcase
    end

    //////////////////////////////////////////////////
    // FSM

    always_comb begin
        state_next = state;
        case (state)
            lsu_pkg::ST_IDLE: begin
                if (ram_re) begin
                    state_next = lsu_pkg::ST_LOAD_HOLD;
                end
            end
            lsu_pkg::ST_LOAD_HOLD: begin
                // Released on the ack edge
                if (load_ack) begin
                    state_next = lsu_pkg::ST_IDLE;
                end
            end
            default: state_next = lsu_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Load attributes for the aligner and result port
    always_ff @(posedge clk) begin
        if (ram_re) begin
            load_id       <= oldest_id;
            load_byte_off <= head_addr[1:0];
            load_size     <= head_size;
            load_unsigned <= head_unsigned;
        end
    end

    assign load_valid = (state == lsu_pkg::ST_LOAD_HOLD);

endmodule

/* src/load_store_unit.sv */
/*
 * Load/store unit top level
 * Connects the queue, control, data RAM and load aligner
 */
module load_store_unit (
    input  logic                  clk,
    input  logic                  rst,
    // Request port
    input  logic                  req_valid,
    input  lsu_pkg::id_t          req_id,
    input  logic                  req_load,
    input  logic                  req_store,
    input  lsu_pkg::addr_t        req_addr,
    input  lsu_pkg::access_size_t req_size,
    input  logic                  req_unsigned,
    input  lsu_pkg::word_t        req_data,
    input  logic                  req_data_valid,
    input  lsu_pkg::id_t          req_data_id,
    output logic                  req_ready,
    // Writeback port
    input  logic                  wb_valid,
    input  lsu_pkg::id_t          wb_id,
    input  lsu_pkg::word_t        wb_data,
    // Conflict port
    input  lsu_pkg::addr_t        cmp_addr,
    output logic                  addr_conflict,
    // Load result
    output logic                  load_valid,
    output lsu_pkg::word_t        load_data,
    output lsu_pkg::id_t          load_id,
    input  logic                  load_ack
);

    // Queue head to control
    logic                       head_ready;
    logic                       head_load;
    lsu_pkg::addr_t             head_addr;
    lsu_pkg::access_size_t      head_size;
    logic                       head_unsigned;
    lsu_pkg::word_t             head_data;
    lsu_pkg::id_t               oldest_id;
    logic                       issue;

    // RAM port
    logic                       ram_we;
    logic                       ram_re;
    logic [lsu_pkg::RAM_AW-1:0] ram_addr;
    lsu_pkg::byte_en_t          ram_be;
    lsu_pkg::word_t             ram_wdata;
    lsu_pkg::word_t             ram_rdata;

    // Registered load attributes
    logic [1:0]                 load_byte_off;
    lsu_pkg::access_size_t      load_size;
    logic                       load_unsigned;

    // Port names match the signals above
    load_store_queue load_store_queue_inst (.*);

    lsu_control lsu_control_inst (.*);

    data_ram data_ram_inst (
        .clk   (clk),
        .we    (ram_we),
        .re    (ram_re),
        .addr  (ram_addr),
        .be    (ram_be),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    load_align load_align_inst (
        .word        (ram_rdata),
        .byte_off    (load_byte_off),
        .size        (load_size),
        .is_unsigned (load_unsigned),
        .data        (load_data)
    );

endmodule

/* tests/load_store_unit_sva.sv */
/*
 * Load/store unit protocol assertions
 * Bound to the top level, watches the load result port and RAM strobes
 */
module load_store_unit_sva (
    input logic           clk,
    input logic           rst,
    input logic           load_valid,
    input logic           load_ack,
    input lsu_pkg::word_t load_data,
    input lsu_pkg::id_t   load_id,
    input logic           ram_we,
    input logic           ram_re
);

    // Result frozen until the ack edge
    result_stable: assert property (
        @(posedge clk) disable iff (rst)
        load_valid && !load_ack |=> $stable(load_data) && $stable(load_id)
    ) else $error("load result changed while load_ack was low");

    // One RAM access per cycle
    ram_single_access: assert property (
        @(posedge clk) disable iff (rst)
        !(ram_we && ram_re)
    ) else $error("RAM write and read enables high together");

    no_result_after_reset: assert property (
        @(posedge clk)
        rst |=> !load_valid
    ) else $error("load_valid high in the cycle after reset");

endmodule

bind load_store_unit load_store_unit_sva load_store_unit_sva_inst (
    .clk        (clk),
    .rst        (rst),
    .load_valid (load_valid),
    .load_ack   (load_ack),
    .load_data  (load_data),
    .load_id    (load_id),
    .ram_we     (ram_we),
    .ram_re     (ram_re)
);

/* tests/load_store_unit_tb.sv */
/*
 * Load/store unit testbench
 * Table of requests, writebacks and conflict checks against a byte-array
 * reference memory, with load acks held back for random cycle counts
 */
module load_store_unit_tb;

    typedef enum logic [2:0] {
        OP_STORE, OP_STORE_WAIT, OP_LOAD, OP_LOAD_U, OP_WB, OP_CMP, OP_CHECK, OP_IDLE
    } op_t;

    // One table row with unused fields left at zero
    typedef struct packed {
        op_t                   op;
        lsu_pkg::id_t          id;
        lsu_pkg::addr_t        addr;
        lsu_pkg::access_size_t size;
        lsu_pkg::word_t        data;
        lsu_pkg::id_t          data_id;
        logic                  exp;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    logic                  req_load;
    logic                  req_store;
    logic                  req_unsigned;
    logic                  req_data_valid;
    lsu_pkg::id_t          req_id;
    lsu_pkg::id_t          req_data_id;
    lsu_pkg::id_t          wb_id;
    lsu_pkg::id_t          load_id;
    lsu_pkg::addr_t        req_addr;
    lsu_pkg::addr_t        cmp_addr;
    lsu_pkg::access_size_t req_size;
    lsu_pkg::word_t        req_data;
    lsu_pkg::word_t        wb_data;
    lsu_pkg::word_t        load_data;
    logic                  req_ready;
    logic                  wb_valid;
    logic                  addr_conflict;
    logic                  load_valid;
    logic                  load_ack;

    row_t                  rows [$];
    // Loads in request order for matching results
    row_t                  load_order [$];
    logic [7:0]            ref_mem [256];
    // Stores waiting on a writeback by producer id
    logic                  wb_pending [lsu_pkg::MAX_INFLIGHT];
    lsu_pkg::addr_t        wb_addr [lsu_pkg::MAX_INFLIGHT];
    lsu_pkg::access_size_t wb_size [lsu_pkg::MAX_INFLIGHT];
    int                    checks;
    int                    errors;

    load_store_unit load_store_unit_inst (.*);

    always #5 clk = ~clk;

    task automatic check_value(input string name, input lsu_pkg::word_t exp,
                               input lsu_pkg::word_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic add_row(input op_t op, input lsu_pkg::id_t id, input lsu_pkg::addr_t addr,
                           input lsu_pkg::access_size_t size, input lsu_pkg::word_t data,
                           input lsu_pkg::id_t data_id, input logic exp);
        row_t r;
        r = '{op, id, addr, size, data, data_id, exp};
        rows.push_back(r);
    endtask

    //////////////////////////////////////////////////
    // Little endian byte reference memory

    task automatic write_ref(input lsu_pkg::addr_t a, input lsu_pkg::access_size_t s,
                             input lsu_pkg::word_t d);
        ref_mem[a[7:0]] = d[7:0];
        if (s != lsu_pkg::SIZE_BYTE) begin
            ref_mem[a[7:0] + 8'd1] = d[15:8];
        end
        if (s == lsu_pkg::SIZE_WORD) begin
            ref_mem[a[7:0] + 8'd2] = d[23:16];
            ref_mem[a[7:0] + 8'd3] = d[31:24];
        end
    endtask

    function automatic lsu_pkg::word_t predict_load(input lsu_pkg::addr_t a,
                                                    input lsu_pkg::access_size_t s,
                                                    input logic uns);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = ref_mem[a[7:0]];
        b1 = ref_mem[a[7:0] + 8'd1];
        if (s == lsu_pkg::SIZE_BYTE) begin
            return uns ? {24'h0, b0} : {{24{b0[7]}}, b0};
        end
        if (s == lsu_pkg::SIZE_HALF) begin
            return uns ? {16'h0, b1, b0} : {{16{b1[7]}}, b1, b0};
        end
        return {ref_mem[a[7:0] + 8'd3], ref_mem[a[7:0] + 8'd2], b1, b0};
    endfunction

    //////////////////////////////////////////////////
    // Row actions start and end on a falling edge

    task automatic send_request(input row_t r);
        int tries;
        tries          = 0;
        req_valid      = 1'b1;
        req_id         = r.id;
        req_load       = (r.op == OP_LOAD) || (r.op == OP_LOAD_U);
        req_store      = !req_load;
        req_addr       = r.addr;
        req_size       = r.size;
        req_unsigned   = (r.op == OP_LOAD_U);
        req_data       = r.data;
        req_data_valid = (r.op == OP_STORE);
        req_data_id    = r.data_id;
        #2;
        // No writeback is captured during a request, so the port must be ready
        check_value("req_ready", 32'd1, 32'(req_ready));
        while (!req_ready && tries < 20) begin
            @(negedge clk);
            #2;
            tries++;
        end
        if (!req_ready) begin
            errors++;
            $display("Timeout: request id %0d was never accepted", r.id);
        end
        @(negedge clk);
        req_valid = 1'b0;
        if (req_load) begin
            load_order.push_back(r);
        end else if (req_data_valid) begin
            write_ref(r.addr, r.size, r.data);
        end else begin
            wb_pending[r.data_id] = 1'b1;
            wb_addr[r.data_id]    = r.addr;
            wb_size[r.data_id]    = r.size;
        end
    endtask

    task automatic send_writeback(input row_t r);
        wb_valid = 1'b1;
        wb_id    = r.id;
        wb_data  = r.data;
        @(negedge clk);
        wb_valid = 1'b0;
        if (wb_pending[r.id]) begin
            write_ref(wb_addr[r.id], wb_size[r.id], r.data);
            wb_pending[r.id] = 1'b0;
        end
    endtask

    task automatic check_conflict(input row_t r);
        cmp_addr = r.addr;
        #2;
        check_value("addr_conflict", 32'(r.exp), 32'(addr_conflict));
        @(negedge clk);
    endtask

    task automatic expect_load(input row_t r);
        row_t           ld;
        lsu_pkg::word_t exp_data;
        lsu_pkg::word_t held_data;
        lsu_pkg::id_t   held_id;
        int             tries;
        int             hold;
        ld       = load_order.pop_front();
        exp_data = predict_load(ld.addr, ld.size, ld.op == OP_LOAD_U);
        tries    = 0;
        while (!load_valid && tries < 50) begin
            @(negedge clk);
            tries++;
        end
        if (!load_valid) begin
            errors++;
            $display("Timeout: no load result arrived for id %0d", r.id);
            return;
        end
        check_value("load_id", 32'(r.id), 32'(load_id));
        check_value("load_data", exp_data, load_data);
        held_data = load_data;
        held_id   = load_id;
        // Result must hold while the ack is held back
        hold = 1 + int'($urandom % 6);
        repeat (hold) begin
            @(negedge clk);
            check_value("load_valid", 32'd1, 32'(load_valid));
            check_value("load_data", held_data, load_data);
            check_value("load_id", 32'(held_id), 32'(load_id));
        end
        load_ack = 1'b1;
        @(negedge clk);
        load_ack = 1'b0;
        // Exactly one result released per ack
        check_value("load_valid", 32'd0, 32'(load_valid));
    endtask

    task automatic check_idle(input row_t r);
        repeat (r.data) begin
            check_value("load_valid", 32'd0, 32'(load_valid));
            @(negedge clk);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus table

    task automatic build_table();
        // Word store then word load
        add_row(OP_STORE,      3'd0, 32'h10, lsu_pkg::SIZE_WORD, 32'hdead_beef, 3'd0, 1'b0);
        add_row(OP_LOAD,       3'd1, 32'h10, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_CHECK,      3'd1, 32'h0, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        // Byte stores at every offset of one word
        add_row(OP_STORE,      3'd2, 32'h20, lsu_pkg::SIZE_WORD, 32'h1122_3344, 3'd0, 1'b0);
        add_row(OP_STORE,      3'd3, 32'h20, lsu_pkg::SIZE_BYTE, 32'h80, 3'd0, 1'b0);
        add_row(OP_STORE,      3'd4, 32'h21, lsu_pkg::SIZE_BYTE, 32'hf1, 3'd0, 1'b0);
        add_row(OP_STORE,      3'd5, 32'h22, lsu_pkg::SIZE_BYTE, 32'h12, 3'd0, 1'b0);
        add_row(OP_STORE,      3'd6, 32'h23, lsu_pkg::SIZE_BYTE, 32'hc3, 3'd0, 1'b0);
        add_row(OP_LOAD,       3'd7, 32'h20, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_CHECK,      3'd7, 32'h0, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        // Halfword stores at both offsets
        add_row(OP_STORE,      3'd0, 32'h24, lsu_pkg::SIZE_WORD, 32'hffff_ffff, 3'd0, 1'b0);
        add_row(OP_STORE,      3'd1, 32'h24, lsu_pkg::SIZE_HALF, 32'h8001, 3'd0, 1'b0);
        add_row(OP_STORE,      3'd2, 32'h26, lsu_pkg::SIZE_HALF, 32'h7ffe, 3'd0, 1'b0);
        add_row(OP_LOAD,       3'd3, 32'h24, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_CHECK,      3'd3, 32'h0, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        // Sign and zero extension with several results queued
        add_row(OP_LOAD,       3'd4, 32'h20, lsu_pkg::SIZE_BYTE, 32'h0, 3'd0, 1'b0);
        add_row(OP_LOAD_U,     3'd5, 32'h20, lsu_pkg::SIZE_BYTE, 32'h0, 3'd0, 1'b0);
        add_row(OP_LOAD,       3'd6, 32'h24, lsu_pkg::SIZE_HALF, 32'h0, 3'd0, 1'b0);
        add_row(OP_LOAD_U,     3'd7, 32'h26, lsu_pkg::SIZE_HALF, 32'h0, 3'd0, 1'b0);
        add_row(OP_CHECK,      3'd4, 32'h0, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_CHECK,      3'd5, 32'h0, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_CHECK,      3'd6, 32'h0, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_CHECK,      3'd7, 32'h0, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_LOAD,       3'd0, 32'h23, lsu_pkg::SIZE_BYTE, 32'h0, 3'd0, 1'b0);
        add_row(OP_LOAD_U,     3'd1, 32'h24, lsu_pkg::SIZE_HALF, 32'h0, 3'd0, 1'b0);
        add_row(OP_LOAD,       3'd2, 32'h22, lsu_pkg::SIZE_HALF, 32'h0, 3'd0, 1'b0);
        add_row(OP_CHECK,      3'd0, 32'h0, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_CHECK,      3'd1, 32'h0, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_CHECK,      3'd2, 32'h0, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        // Store waiting on producer 6 blocks the loads behind it
        add_row(OP_CMP,        3'd0, 32'h40, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_STORE_WAIT, 3'd3, 32'h40, lsu_pkg::SIZE_WORD, 32'h0, 3'd6, 1'b0);
        add_row(OP_LOAD,       3'd4, 32'h40, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_LOAD_U,     3'd5, 32'h22, lsu_pkg::SIZE_HALF, 32'h0, 3'd0, 1'b0);
        add_row(OP_CMP,        3'd0, 32'h38, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b1);
        add_row(OP_CMP,        3'd0, 32'h62, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_IDLE,       3'd0, 32'h0, lsu_pkg::SIZE_WORD, 32'd5, 3'd0, 1'b0);
        add_row(OP_WB,         3'd6, 32'h0, lsu_pkg::SIZE_WORD, 32'hcafe_f00d, 3'd0, 1'b0);
        add_row(OP_CMP,        3'd0, 32'h40, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b1);
        add_row(OP_CMP,        3'd0, 32'h40, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_CHECK,      3'd4, 32'h0, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_CHECK,      3'd5, 32'h0, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        // Waiting halfword store with lanes filled from the writeback
        add_row(OP_STORE,      3'd2, 32'h44, lsu_pkg::SIZE_WORD, 32'h0102_0304, 3'd0, 1'b0);
        add_row(OP_STORE_WAIT, 3'd0, 32'h46, lsu_pkg::SIZE_HALF, 32'h0, 3'd7, 1'b0);
        add_row(OP_LOAD,       3'd1, 32'h44, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
        add_row(OP_CMP,        3'd0, 32'h0e, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b1);
        add_row(OP_WB,         3'd7, 32'h0, lsu_pkg::SIZE_WORD, 32'h1234_5aa5, 3'd0, 1'b0);
        add_row(OP_CHECK,      3'd1, 32'h0, lsu_pkg::SIZE_WORD, 32'h0, 3'd0, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h17cd_08c3));
        checks         = 0;
        errors         = 0;
        clk            = 1'b0;
        rst            = 1'b1;
        req_valid      = 1'b0;
        req_id         = '0;
        req_load       = 1'b0;
        req_store      = 1'b0;
        req_addr       = '0;
        req_size       = lsu_pkg::SIZE_WORD;
        req_unsigned   = 1'b0;
        req_data       = '0;
        req_data_valid = 1'b0;
        req_data_id    = '0;
        wb_valid       = 1'b0;
        wb_id          = '0;
        wb_data        = '0;
        cmp_addr       = '0;
        load_ack       = 1'b0;
        for (int i = 0; i < lsu_pkg::MAX_INFLIGHT; i++) begin
            wb_pending[i] = 1'b0;
        end
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Clean state right after reset for every tag value
        check_value("load_valid", 32'd0, 32'(load_valid));
        for (int t = 0; t < 8; t++) begin
            cmp_addr = ($urandom & 32'hffff_fff8) | 32'(t);
            #2;
            check_value("addr_conflict", 32'd0, 32'(addr_conflict));
            @(negedge clk);
        end

        foreach (rows[i]) begin
            case (rows[i].op)
                OP_WB:    send_writeback(rows[i]);
                OP_CMP:   check_conflict(rows[i]);
                OP_CHECK: expect_load(rows[i]);
                OP_IDLE:  check_idle(rows[i]);
                default:  send_request(rows[i]);
            endcase
        end
        repeat (2) @(negedge clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
src/lsu_pkg.sv
src/id_fifo.sv
src/load_store_queue.sv
src/data_ram.sv
src/load_align.sv
src/lsu_control.sv
src/load_store_unit.sv
tests/load_store_unit_sva.sv
tests/load_store_unit_tb.sv

/* Makefile */
# Verilator build and run of the load/store unit testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module load_store_unit_tb \
		-f flist.f -o load_store_unit_sim
	./obj_dir/load_store_unit_sim | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
